//--- src/sys_ctrl_settings.svh
`ifndef SYS_CTRL_SETTINGS_SVH
`define SYS_CTRL_SETTINGS_SVH

// bus and data widths
`define SC_ADDR_W          32
`define SC_DATA_W          32
`define SC_STRB_W          4
`define SC_INT_NUM         32
`define SC_TIME_W          64

// bit 12 of the address picks cfgreg (0) or intc (1)
`define SC_DEC_BIT         12
`define SC_MAP_LIMIT       32'h0000_2000

// clocks per system timer tick
`define SC_SYSTIME_DIV     4

// configuration block offsets
`define CFG_DDR_OFFSET     12'h000
`define CFG_BOOTVEC        12'h004
`define CFG_CORE_RST       12'h008

// interrupt controller offsets
`define INTC_MSIP          12'h000
`define INTC_MTIMECMP_LO   12'h004
`define INTC_MTIMECMP_HI   12'h008
`define INTC_MTIME_LO      12'h00c
`define INTC_MTIME_HI      12'h010
`define INTC_MEIE          12'h014
`define INTC_SEIE          12'h018
`define INTC_PEND          12'h01c

// reset values
`define CFG_BOOTVEC_RST    32'h0000_0000
`define CFG_DDR_OFFSET_RST 32'h0000_0000

`endif

//--- src/sys_ctrl_pkg.sv
`include "sys_ctrl_settings.svh"

package sys_ctrl_pkg;

    // requester side of an APB transfer
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic [`SC_ADDR_W-1:0]   paddr;
        logic                    pwrite;
        logic [`SC_STRB_W-1:0]   pstrb;
        logic [`SC_DATA_W-1:0]   pwdata;
    } apb_req_t;

    // completer side
    typedef struct packed {
        logic [`SC_DATA_W-1:0]   prdata;
        logic                    pslverr;
        logic                    pready;
    } apb_rsp_t;

    // interrupt lines toward the core
    typedef struct packed {
        logic                    msip;
        logic                    mtip;
        logic                    meip;
        logic                    seip;
    } irq_lines_t;

    // byte lanes of new_val replace those of old_val where strb is set
    function automatic logic [`SC_DATA_W-1:0] strb_merge(
        input logic [`SC_DATA_W-1:0] old_val,
        input logic [`SC_DATA_W-1:0] new_val,
        input logic [`SC_STRB_W-1:0] strb
    );
        logic [`SC_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `SC_STRB_W; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- src/apb_decoder.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module apb_decoder (
    input  sys_ctrl_pkg::apb_req_t apb_req,
    output sys_ctrl_pkg::apb_rsp_t apb_rsp,

    output sys_ctrl_pkg::apb_req_t cfg_req,
    input  sys_ctrl_pkg::apb_rsp_t cfg_rsp,

    output sys_ctrl_pkg::apb_req_t intc_req,
    input  sys_ctrl_pkg::apb_rsp_t intc_rsp
);

logic mapped;
logic sel_intc;
logic access;

assign mapped   = apb_req.paddr < `SC_MAP_LIMIT;
assign sel_intc = apb_req.paddr[`SC_DEC_BIT];
assign access   = apb_req.psel & apb_req.penable;

// only psel differs between the two target requests
always_comb begin
    cfg_req       = apb_req;
    cfg_req.psel  = apb_req.psel & mapped & ~sel_intc;
    intc_req      = apb_req;
    intc_req.psel = apb_req.psel & mapped & sel_intc;
end

// response select
always_comb begin
    if (!mapped) begin
        // unmapped address gets an error response from the decoder itself
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access;
    end
    else if (sel_intc) begin
        apb_rsp = intc_rsp;
    end
    else begin
        apb_rsp = cfg_rsp;
    end
end

endmodule

//--- src/cfgreg.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module cfgreg (
    input                          clk,
    input                          rst_n,
    input  sys_ctrl_pkg::apb_req_t apb_req,
    output sys_ctrl_pkg::apb_rsp_t apb_rsp,

    output logic [`SC_DATA_W-1:0]  ddr_offset,
    output logic [`SC_DATA_W-1:0]  core_bootvec,
    output logic                   core_rstn
);

logic [`SC_DEC_BIT-1:0] offset;
logic                   wr_en;
logic                   core_rst;
logic [`SC_DATA_W-1:0]  rdata;

assign offset = apb_req.paddr[`SC_DEC_BIT-1:0];
assign wr_en  = apb_req.psel & apb_req.penable & apb_req.pwrite;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        ddr_offset   <= `CFG_DDR_OFFSET_RST;
        core_bootvec <= `CFG_BOOTVEC_RST;
        // core held in reset until software releases it
        core_rst     <= 1'b1;
    end
    else if (wr_en) begin
        case (offset)
            `CFG_DDR_OFFSET: ddr_offset <= sys_ctrl_pkg::strb_merge(ddr_offset,
                                           apb_req.pwdata, apb_req.pstrb);
            `CFG_BOOTVEC:    core_bootvec <= sys_ctrl_pkg::strb_merge(core_bootvec,
                                             apb_req.pwdata, apb_req.pstrb);
            `CFG_CORE_RST: begin
                if (apb_req.pstrb[0]) begin
                    core_rst <= apb_req.pwdata[0];
                end
            end
            default: ;
        endcase
    end
end

assign core_rstn = ~core_rst;

// undefined offsets read as zero
always_comb begin
    case (offset)
        `CFG_DDR_OFFSET: rdata = ddr_offset;
        `CFG_BOOTVEC:    rdata = core_bootvec;
        `CFG_CORE_RST:   rdata = {{(`SC_DATA_W-1){1'b0}}, core_rst};
        default:         rdata = '0;
    endcase
end

// no wait states
assign apb_rsp.prdata  = rdata;
assign apb_rsp.pready  = apb_req.psel & apb_req.penable;
assign apb_rsp.pslverr = 1'b0;

endmodule

//--- src/systimer.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module systimer #(
    parameter int DIV = `SC_SYSTIME_DIV
) (
    input                          clk,
    input                          rst_n,
    output logic [`SC_TIME_W-1:0]  systime
);

localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

logic [CNT_W-1:0] presc;
logic             tick;

// one tick every DIV clocks
assign tick = (presc == CNT_W'(DIV - 1));

always_ff @(posedge clk) begin
    if (!rst_n) begin
        presc   <= '0;
        systime <= '0;
    end
    else begin
        presc <= tick ? '0 : presc + 1'b1;
        if (tick) begin
            systime <= systime + 1'b1;
        end
    end
end

endmodule

//--- src/intc.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module intc (
    input                            clk,
    input                            rst_n,
    input  sys_ctrl_pkg::apb_req_t   apb_req,
    output sys_ctrl_pkg::apb_rsp_t   apb_rsp,

    input        [`SC_TIME_W-1:0]    systime,
    input        [`SC_INT_NUM-1:0]   ints,
    output sys_ctrl_pkg::irq_lines_t irq
);

logic [`SC_DEC_BIT-1:0] offset;
logic                   wr_en;

logic                   msip;
logic [`SC_DATA_W-1:0]  mtimecmp_lo;
logic [`SC_DATA_W-1:0]  mtimecmp_hi;
logic [`SC_INT_NUM-1:0] meie;
logic [`SC_INT_NUM-1:0] seie;
logic [`SC_INT_NUM-1:0] pend;

logic                   mtip;
logic                   meip;
logic                   seip;
logic [`SC_DATA_W-1:0]  rdata;

assign offset = apb_req.paddr[`SC_DEC_BIT-1:0];
assign wr_en  = apb_req.psel & apb_req.penable & apb_req.pwrite;

// software writable registers
always_ff @(posedge clk) begin
    if (!rst_n) begin
        msip        <= 1'b0;
        mtimecmp_lo <= '1;
        mtimecmp_hi <= '1;
        meie        <= '0;
        seie        <= '0;
    end
    else if (wr_en) begin
        case (offset)
            `INTC_MSIP: begin
                if (apb_req.pstrb[0]) begin
                    msip <= apb_req.pwdata[0];
                end
            end
            `INTC_MTIMECMP_LO: mtimecmp_lo <= sys_ctrl_pkg::strb_merge(mtimecmp_lo,
                                              apb_req.pwdata, apb_req.pstrb);
            `INTC_MTIMECMP_HI: mtimecmp_hi <= sys_ctrl_pkg::strb_merge(mtimecmp_hi,
                                              apb_req.pwdata, apb_req.pstrb);
            `INTC_MEIE:        meie <= sys_ctrl_pkg::strb_merge(meie,
                                       apb_req.pwdata, apb_req.pstrb);
            `INTC_SEIE:        seie <= sys_ctrl_pkg::strb_merge(seie,
                                       apb_req.pwdata, apb_req.pstrb);
            // mtime and pending are read only
            default: ;
        endcase
    end
end

// external lines sampled every clock
always_ff @(posedge clk) begin
    pend <= ints;
end

// registered interrupt outputs
always_ff @(posedge clk) begin
    if (!rst_n) begin
        mtip <= 1'b0;
        meip <= 1'b0;
        seip <= 1'b0;
    end
    else begin
        mtip <= systime >= {mtimecmp_hi, mtimecmp_lo};
        meip <= |(pend & meie);
        seip <= |(pend & seie);
    end
end

always_comb begin
    irq.msip = msip;
    irq.mtip = mtip;
    irq.meip = meip;
    irq.seip = seip;
end

always_comb begin
    case (offset)
        `INTC_MSIP:        rdata = {{(`SC_DATA_W-1){1'b0}}, msip};
        `INTC_MTIMECMP_LO: rdata = mtimecmp_lo;
        `INTC_MTIMECMP_HI: rdata = mtimecmp_hi;
        `INTC_MTIME_LO:    rdata = systime[`SC_DATA_W-1:0];
        `INTC_MTIME_HI:    rdata = systime[`SC_TIME_W-1:`SC_DATA_W];
        `INTC_MEIE:        rdata = meie;
        `INTC_SEIE:        rdata = seie;
        `INTC_PEND:        rdata = pend;
        default:           rdata = '0;
    endcase
end

assign apb_rsp.prdata  = rdata;
assign apb_rsp.pready  = apb_req.psel & apb_req.penable;
assign apb_rsp.pslverr = 1'b0;

endmodule

//--- src/sys_ctrl_top.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module sys_ctrl_top (
    input                            clk,
    input                            rst_n,
    input  sys_ctrl_pkg::apb_req_t   apb_req,
    output sys_ctrl_pkg::apb_rsp_t   apb_rsp,
    input        [`SC_INT_NUM-1:0]   ints,
    output sys_ctrl_pkg::irq_lines_t irq,
    output logic [`SC_DATA_W-1:0]    ddr_offset,
    output logic [`SC_DATA_W-1:0]    core_bootvec,
    output logic                     core_rstn
);

sys_ctrl_pkg::apb_req_t cfg_req;
sys_ctrl_pkg::apb_rsp_t cfg_rsp;
sys_ctrl_pkg::apb_req_t intc_req;
sys_ctrl_pkg::apb_rsp_t intc_rsp;
logic [`SC_TIME_W-1:0]  systime;

apb_decoder u_apb_decoder (
    .apb_req  ( apb_req  ),
    .apb_rsp  ( apb_rsp  ),
    .cfg_req  ( cfg_req  ),
    .cfg_rsp  ( cfg_rsp  ),
    .intc_req ( intc_req ),
    .intc_rsp ( intc_rsp )
);

cfgreg u_cfgreg (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .apb_req      ( cfg_req      ),
    .apb_rsp      ( cfg_rsp      ),
    .ddr_offset   ( ddr_offset   ),
    .core_bootvec ( core_bootvec ),
    .core_rstn    ( core_rstn    )
);

intc u_intc (
    .clk     ( clk      ),
    .rst_n   ( rst_n    ),
    .apb_req ( intc_req ),
    .apb_rsp ( intc_rsp ),
    .systime ( systime  ),
    .ints    ( ints     ),
    .irq     ( irq      )
);

systimer #(
    .DIV ( `SC_SYSTIME_DIV )
) u_systimer (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .systime ( systime )
);

endmodule

//--- test/sys_ctrl_assert.sv
`timescale 1ns/100ps

module sys_ctrl_assert (
    input                            clk,
    input                            rst_n,
    input  sys_ctrl_pkg::apb_req_t   apb_req,
    input  sys_ctrl_pkg::apb_rsp_t   apb_rsp,
    input                            core_rstn,
    input  sys_ctrl_pkg::irq_lines_t irq
);

// number of assertion failures so far
int fail_cnt = 0;

// completer answers only in the access cycle
ap_rsp_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pready && !apb_rsp.pslverr)
    else begin
        $error("pready or pslverr high outside an access cycle");
        fail_cnt++;
    end

// setup cycle is followed by an access cycle with the same request
ap_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable &&
    $stable({apb_req.paddr, apb_req.pwrite, apb_req.pstrb, apb_req.pwdata}))
    else begin
        $error("APB request changed between setup and access cycle");
        fail_cnt++;
    end

// core still held in reset right after system reset
ap_core_held: assert property (@(posedge clk) $rose(rst_n) |-> !core_rstn)
    else begin
        $error("core_rstn not low in the first cycle after reset");
        fail_cnt++;
    end

ap_irq_quiet: assert property (@(posedge clk) $rose(rst_n) |-> irq == '0)
    else begin
        $error("irq lines not low in the first cycle after reset");
        fail_cnt++;
    end

endmodule

//--- test/sys_ctrl_tb.sv
`timescale 1ns/100ps
`include "sys_ctrl_settings.svh"

module sys_ctrl_tb;

localparam int          max_steps = 64;
localparam int          rec_w     = 5;
localparam logic [31:0] intc_base = 32'h1 << `SC_DEC_BIT;

logic                     clk;
logic                     rst_n;
sys_ctrl_pkg::apb_req_t   apb_req;
sys_ctrl_pkg::apb_rsp_t   apb_rsp;
logic [`SC_INT_NUM-1:0]   ints;
sys_ctrl_pkg::irq_lines_t irq;
logic [3:0]               irq_bits;
logic [`SC_DATA_W-1:0]    ddr_offset;
logic [`SC_DATA_W-1:0]    core_bootvec;
logic                     core_rstn;

// five words per step in the order op, addr, data, strb, expected
logic [63:0] tdata [0:max_steps*rec_w-1];
int          n_steps;
logic        loaded;

assign irq_bits = irq;

sys_ctrl_top u_sys_ctrl_top (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .apb_req      ( apb_req      ),
    .apb_rsp      ( apb_rsp      ),
    .ints         ( ints         ),
    .irq          ( irq          ),
    .ddr_offset   ( ddr_offset   ),
    .core_bootvec ( core_bootvec ),
    .core_rstn    ( core_rstn    )
);

bind sys_ctrl_top sys_ctrl_assert u_sys_ctrl_assert (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .apb_req   ( apb_req   ),
    .apb_rsp   ( apb_rsp   ),
    .core_rstn ( core_rstn ),
    .irq       ( irq       )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped after the first error");
endtask

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end_with_failure();
    end
endtask

// one two-cycle transfer with the request held until the access cycle ends
task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] strb, output logic [31:0] rdata);
    @(posedge clk);
    #10;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwrite  = wr;
    apb_req.pstrb   = wr ? strb : 4'h0;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #10;
    apb_req.penable = 1'b1;
    @(negedge clk);
    check_value(apb_rsp.pready, 1'b1, "pready in first access cycle");
    check_value(apb_rsp.pslverr, addr >= `SC_MAP_LIMIT, "pslverr for this address");
    rdata = apb_rsp.prdata;
    @(posedge clk);
    #10;
    apb_req = '0;
endtask

task automatic read_mtime(output logic [63:0] t);
    logic [31:0] lo;
    logic [31:0] hi;
    apb_xfer(1'b0, intc_base | `INTC_MTIME_LO, '0, '0, lo);
    apb_xfer(1'b0, intc_base | `INTC_MTIME_HI, '0, '0, hi);
    t = {hi, lo};
endtask

// compare point a fixed number of ticks ahead of the current time
task automatic arm_timer(input logic [31:0] delta);
    logic [63:0] t1;
    logic [63:0] t2;
    logic [63:0] target;
    logic [31:0] rd;
    read_mtime(t1);
    repeat (8) @(posedge clk);
    #10;
    read_mtime(t2);
    check_value(t2 > t1, 1'b1, "mtime advances between reads");
    target = t2 + delta;
    apb_xfer(1'b1, intc_base | `INTC_MTIMECMP_LO, target[31:0], 4'hf, rd);
    apb_xfer(1'b1, intc_base | `INTC_MTIMECMP_HI, target[63:32], 4'hf, rd);
    @(negedge clk);
    check_value(irq.mtip, 1'b0, "mtip right after arming");
endtask

task automatic wait_irq(input int max_cycles, input logic [3:0] mask, input logic [3:0] want);
    int n;
    n = 0;
    @(negedge clk);
    while (((irq_bits & mask) != want) && n < max_cycles) begin
        @(negedge clk);
        n++;
    end
    check_value(irq_bits & mask, want, "irq lines after polling");
endtask

task automatic check_outputs(input logic [63:0] sel, input logic [63:0] expected);
    @(negedge clk);
    case (sel)
        0: check_value(ddr_offset, expected, "ddr_offset output");
        1: check_value(core_bootvec, expected, "core_bootvec output");
        2: check_value(core_rstn, expected, "core_rstn output");
        3: check_value(irq_bits, expected, "irq lines {msip,mtip,meip,seip}");
        default: begin
            $display("ERROR: the test data selects an output that does not exist");
            end_with_failure();
        end
    endcase
endtask

always @(posedge clk) begin
    if (u_sys_ctrl_top.u_sys_ctrl_assert.fail_cnt != 0) begin
        $display("ERROR: a bound APB or reset assertion failed");
        end_with_failure();
    end
end

initial begin
    wait (loaded === 1'b1);
    repeat (n_steps * 50 + 2000) @(posedge clk);
    $display("ERROR: timeout, the test steps did not finish in time");
    end_with_failure();
end

initial begin
    logic [63:0] op;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] strb;
    logic [63:0] expv;
    logic [31:0] rd;
    rst_n   = 1'b0;
    apb_req = '0;
    ints    = '0;
    loaded  = 1'b0;
    n_steps = 0;
    void'($urandom(32'he83d_34b5));
    for (int i = 0; i < max_steps * rec_w; i++) begin
        tdata[i] = '0;
    end
    $readmemh("test/sys_ctrl_testdata.txt", tdata);
    while (n_steps < max_steps && tdata[n_steps*rec_w] != 0) begin
        n_steps++;
    end
    if (n_steps == 0) begin
        $display("ERROR: no test steps found in the test data file");
        end_with_failure();
    end
    loaded = 1'b1;

    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;

    for (int s = 0; s < n_steps; s++) begin
        op   = tdata[s*rec_w];
        addr = tdata[s*rec_w+1];
        data = tdata[s*rec_w+2];
        strb = tdata[s*rec_w+3];
        expv = tdata[s*rec_w+4];
        repeat ($urandom % 3) @(posedge clk);
        case (op)
            1: apb_xfer(1'b1, addr[31:0], data[31:0], strb[3:0], rd);
            2: begin
                apb_xfer(1'b0, addr[31:0], '0, '0, rd);
                check_value(rd, expv, $sformatf("read data at %h", addr[31:0]));
            end
            3: begin
                @(posedge clk);
                #10;
                ints = data[`SC_INT_NUM-1:0];
            end
            4: wait_irq(addr, data[3:0], expv[3:0]);
            5: begin
                repeat (addr) @(posedge clk);
                #10;
            end
            6: check_outputs(addr, expv);
            7: arm_timer(addr[31:0]);
            default: begin
                $display("ERROR: unknown operation code in test step %0d", s);
                end_with_failure();
            end
        endcase
    end

    repeat (2) @(posedge clk);
    if (u_sys_ctrl_top.u_sys_ctrl_assert.fail_cnt == 0) begin
        $display(">>> PASS");
        $finish;
    end
    else begin
        $display("ERROR: a bound assertion failed near the end of the run");
        end_with_failure();
    end
end

endmodule

//--- compile.f
+incdir+src
src/sys_ctrl_pkg.sv
src/apb_decoder.sv
src/cfgreg.sv
src/systimer.sv
src/intc.sv
src/sys_ctrl_top.sv
test/sys_ctrl_assert.sv
test/sys_ctrl_tb.sv

//--- test/sys_ctrl_testdata.txt
// columns: op addr data strb expected, all hex, pslverr follows from the address
// op 1 write, 2 read, 3 ints, 4 wait_irq, 5 idle, 6 check output, 7 arm timer
// check output addr 0 ddr_offset, 1 core_bootvec, 2 core_rstn, 3 irq {msip,mtip,meip,seip}
6 0 0 0 0
6 1 0 0 0
6 2 0 0 0
6 3 0 0 0
2 8 0 0 1
1 0 a5a5a5a5 f 0
1 0 12345678 3 0
2 0 0 0 a5a55678
6 0 0 0 a5a55678
1 4 80001000 f 0
1 4 00ab0000 4 0
2 4 0 0 80ab1000
6 1 0 0 80ab1000
1 8 0 1 0
6 2 0 0 1
2 8 0 0 0
2 10 0 0 0
2 2000 0 0 0
1 3ffc deadbeef f 0
1 1000 1 1 0
6 3 0 0 8
1 1000 0 1 0
6 3 0 0 0
3 0 0000f0f0 0 0
1 1014 00000010 f 0
1 1018 00000100 f 0
2 101c 0 0 0000f0f0
1 101c ffffffff f 0
2 101c 0 0 0000f0f0
5 2 0 0 0
6 3 0 0 2
3 0 0000000f 0 0
5 2 0 0 0
6 3 0 0 0
3 0 00000100 0 0
5 2 0 0 0
6 3 0 0 1
1 1018 0 f 0
5 2 0 0 0
6 3 0 0 0
7 14 0 0 0
4 5a 4 0 4
1 1004 ffffffff f 0
1 1008 ffffffff f 0
2 1008 0 0 ffffffff
5 2 0 0 0
6 3 0 0 0
